// File: common/tile_pkg.sv
`default_nettype none

package tile_pkg;

	////////////////////
	// Tile geometry
	////////////////////

	// Pixels per tile row, one per CLK_6M
	localparam int TILE_W = 8;
	// Width of the pixel phase counter inside a tile
	localparam int PHASE_W = $clog2(TILE_W);
	// Last pixel of a tile, where the next tile is loaded
	localparam logic [PHASE_W-1:0] LAST_PHASE = PHASE_W'(TILE_W - 1);
	// Tile column counter width
	localparam int COL_W = 6;

	////////////////////
	// Pixel formats
	////////////////////

	// Bit-planes per pixel, so also the dot width
	localparam int PLANES = 3;
	// One half-tile is four pixels per plane
	localparam int NIBBLE_W = TILE_W / 2;
	// Half-tile word, plane 0 in bits 3:0, plane 1 in 7:4, plane 2 in 11:8
	// Nibble MSB is the leftmost pixel, LO half is pixels 0-3, HI half 4-7
	localparam int GDI_W = PLANES * NIBBLE_W;
	// Colour attribute from the map
	localparam int ATTR_W = 8;
	localparam int PRIO_W = 3;
	// All planes set means see-through
	localparam logic [PLANES-1:0] DOT_TRANSPARENT = 3'd7;

	// Graphics fetch requested from tile memory this cycle
	typedef enum logic [2:0] {
		SLOT_NONE = 3'd0,
		SLOT_A_LO = 3'd1,
		SLOT_A_HI = 3'd2,
		SLOT_B_LO = 3'd3,
		SLOT_B_HI = 3'd4
	} fetch_slot_t;

	// Fetch sequencer states
	typedef enum logic [2:0] {
		FS_IDLE  = 3'd0,
		FS_A_LO  = 3'd1,
		FS_A_HI  = 3'd2,
		FS_B_LO  = 3'd3,
		FS_B_HI  = 3'd4,
		FS_DRAIN = 3'd5
	} fetch_state_t;

endpackage

`default_nettype wire

// File: common/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	////////////////////
	// CPU register port
	////////////////////

	// Write data bus width
	localparam int CPU_DW = 8;

	// Register select on cpu_addr
	typedef enum logic [1:0] {
		// Layer A priority in bits 2:0
		REG_PRIO_A = 2'd0,
		// Layer B priority in bits 2:0
		REG_PRIO_B = 2'd1,
		// Flip and layer enables
		REG_CTRL   = 2'd2
	} reg_sel_t;

	////////////////////
	// REG_CTRL bits
	////////////////////

	// Mirror every tile horizontally
	localparam int CTRL_FLIP = 0;
	// Layer A visible
	localparam int CTRL_EN_A = 1;
	// Layer B visible
	localparam int CTRL_EN_B = 2;

	// Bits 7:3 are ignored on write

endpackage

`default_nettype wire

// File: logic/pixel_counter.sv
`default_nettype none

// Pixel phase and tile column of the running line
module pixel_counter (
	input  wire logic CLK_6M,
	input  wire logic reset,
	input  wire logic run,
	output logic [tile_pkg::PHASE_W-1:0] phase,
	output logic [tile_pkg::COL_W-1:0] column,
	output logic tile_end
);

	// Last pixel of a tile while video is running
	assign tile_end = run && (phase == tile_pkg::LAST_PHASE);

	always_ff @(posedge CLK_6M) begin
		if (reset || !run) begin
			// Idle between lines, next column is 0
			phase <= '0;
			column <= '0;
		end else begin
			// Phase wraps naturally at the tile width
			phase <= phase + 1'b1;
			if (tile_end) begin
				column <= column + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/fetch_sequencer.sv
`default_nettype none

// Per-tile fetch schedule
// Phases 0-3 fetch A lo, A hi, B lo, B hi, phases 4-7 are free
module fetch_sequencer (
	input  wire logic CLK_6M,
	input  wire logic reset,
	input  wire logic run,
	input  wire logic [tile_pkg::PHASE_W-1:0] phase,
	input  wire logic tile_end,
	output tile_pkg::fetch_slot_t slot,
	output logic load
);

	tile_pkg::fetch_state_t state;
	tile_pkg::fetch_state_t state_next;

	////////////////////
	// Next state
	////////////////////
	always_comb begin
		state_next = state;
		case (state)
			// First tile of a line, A lo goes out straight from idle
			tile_pkg::FS_IDLE: begin
				if (phase == '0) begin
					state_next = tile_pkg::FS_A_HI;
				end
			end
			tile_pkg::FS_A_LO: state_next = tile_pkg::FS_A_HI;
			tile_pkg::FS_A_HI: state_next = tile_pkg::FS_B_LO;
			tile_pkg::FS_B_LO: state_next = tile_pkg::FS_B_HI;
			tile_pkg::FS_B_HI: state_next = tile_pkg::FS_DRAIN;
			// Wait out phases 4-7
			tile_pkg::FS_DRAIN: begin
				if (tile_end) begin
					state_next = tile_pkg::FS_A_LO;
				end
			end
			default: state_next = tile_pkg::FS_IDLE;
		endcase
		// Line ended, stop wherever we are
		if (!run) begin
			state_next = tile_pkg::FS_IDLE;
		end
	end

	always_ff @(posedge CLK_6M) begin
		if (reset) begin
			state <= tile_pkg::FS_IDLE;
		end else begin
			state <= state_next;
		end
	end

	////////////////////
	// Slot decode
	////////////////////
	always_comb begin
		slot = tile_pkg::SLOT_NONE;
		if (run) begin
			case (state)
				tile_pkg::FS_IDLE: begin
					if (phase == '0) begin
						slot = tile_pkg::SLOT_A_LO;
					end
				end
				tile_pkg::FS_A_LO: slot = tile_pkg::SLOT_A_LO;
				tile_pkg::FS_A_HI: slot = tile_pkg::SLOT_A_HI;
				tile_pkg::FS_B_LO: slot = tile_pkg::SLOT_B_LO;
				tile_pkg::FS_B_HI: slot = tile_pkg::SLOT_B_HI;
				default: slot = tile_pkg::SLOT_NONE;
			endcase
		end
	end

	// Both shifters swap tiles on the last pixel
	assign load = tile_end && (state == tile_pkg::FS_DRAIN);

endmodule

`default_nettype wire

// File: logic/layer_regs.sv
`default_nettype none

// CPU-side control registers, write only
// Four-phase req/ack, one register per handshake
module layer_regs (
	input  wire logic CLK_6M,
	input  wire logic reset,
	input  wire logic cpu_req,
	output logic cpu_ack,
	input  wire ctrl_pkg::reg_sel_t cpu_addr,
	input  wire logic [ctrl_pkg::CPU_DW-1:0] cpu_wdata,
	output logic [tile_pkg::PRIO_W-1:0] prio_a,
	output logic [tile_pkg::PRIO_W-1:0] prio_b,
	output logic flip,
	output logic en_a,
	output logic en_b
);

	// New request not yet acknowledged
	logic wr_en;

	assign wr_en = cpu_req && !cpu_ack;

	////////////////////
	// Handshake
	////////////////////
	always_ff @(posedge CLK_6M) begin
		if (reset) begin
			cpu_ack <= 1'b0;
		end else if (wr_en) begin
			// Ack on the same edge as the write
			cpu_ack <= 1'b1;
		end else if (!cpu_req) begin
			// Host released, close the cycle
			cpu_ack <= 1'b0;
		end
	end

	////////////////////
	// Register file
	////////////////////
	always_ff @(posedge CLK_6M) begin
		if (reset) begin
			prio_a <= '0;
			prio_b <= '0;
			flip <= 1'b0;
			// Both layers on by default
			en_a <= 1'b1;
			en_b <= 1'b1;
		end else if (wr_en) begin
			case (cpu_addr)
				ctrl_pkg::REG_PRIO_A: begin
					prio_a <= cpu_wdata[tile_pkg::PRIO_W-1:0];
				end
				ctrl_pkg::REG_PRIO_B: begin
					prio_b <= cpu_wdata[tile_pkg::PRIO_W-1:0];
				end
				ctrl_pkg::REG_CTRL: begin
					flip <= cpu_wdata[ctrl_pkg::CTRL_FLIP];
					en_a <= cpu_wdata[ctrl_pkg::CTRL_EN_A];
					en_b <= cpu_wdata[ctrl_pkg::CTRL_EN_B];
				end
				// Unmapped select, write is acked and dropped
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: tilemap/plane_shifter.sv
`default_nettype none

// One tile layer: half-tile latches, attribute latch, plane shifters
module plane_shifter #(
	parameter bit LAYER_B = 1'b0
) (
	input  wire logic CLK_6M,
	input  wire logic reset,
	input  wire logic run,
	input  wire tile_pkg::fetch_slot_t slot,
	input  wire logic load,
	input  wire logic [tile_pkg::GDI_W-1:0] gdi,
	input  wire logic [tile_pkg::ATTR_W-1:0] mdi,
	input  wire logic flip,
	output logic [tile_pkg::PLANES-1:0] dot,
	output logic [tile_pkg::ATTR_W-1:0] color
);

	localparam int NIB = tile_pkg::NIBBLE_W;
	localparam int TW = tile_pkg::TILE_W;

	// Slots this layer answers to
	localparam tile_pkg::fetch_slot_t SLOT_LO =
		tile_pkg::fetch_slot_t'(LAYER_B ? tile_pkg::SLOT_B_LO : tile_pkg::SLOT_A_LO);
	localparam tile_pkg::fetch_slot_t SLOT_HI =
		tile_pkg::fetch_slot_t'(LAYER_B ? tile_pkg::SLOT_B_HI : tile_pkg::SLOT_A_HI);

	logic [tile_pkg::GDI_W-1:0] half_lo;
	logic [tile_pkg::GDI_W-1:0] half_hi;
	logic [tile_pkg::ATTR_W-1:0] attr;
	// Bit 7 is pixel 0 of the tile
	logic [TW-1:0] plane_sr [tile_pkg::PLANES];

	////////////////////
	// Fetch latches
	////////////////////
	always_ff @(posedge CLK_6M) begin
		if (slot == SLOT_LO) begin
			half_lo <= gdi;
		end
		// Attribute arrives with the second half
		if (slot == SLOT_HI) begin
			half_hi <= gdi;
			attr <= mdi;
		end
		if (load) begin
			color <= attr;
		end
	end

	////////////////////
	// Plane shifters
	////////////////////
	always_ff @(posedge CLK_6M) begin
		for (int p = 0; p < tile_pkg::PLANES; p++) begin
			if (reset || !run) begin
				// Transparent until the first tile is loaded
				plane_sr[p] <= '1;
			end else if (load) begin
				plane_sr[p] <= {half_lo[p*NIB +: NIB], half_hi[p*NIB +: NIB]};
			end else if (flip) begin
				plane_sr[p] <= {1'b1, plane_sr[p][TW-1:1]};
			end else begin
				plane_sr[p] <= {plane_sr[p][TW-2:0], 1'b1};
			end
		end
	end

	// Mirrored tiles read from the other end
	always_comb begin
		for (int p = 0; p < tile_pkg::PLANES; p++) begin
			dot[p] = flip ? plane_sr[p][0] : plane_sr[p][TW-1];
		end
	end

endmodule

`default_nettype wire

// File: tilemap/layer_mixer.sv
`default_nettype none

// Priority mix of layer A, layer B and the incoming pixel chain
module layer_mixer (
	input  wire logic CLK_6M,
	input  wire logic reset,
	input  wire logic run,
	input  wire logic [tile_pkg::PLANES-1:0] dot_a,
	input  wire logic [tile_pkg::ATTR_W-1:0] color_a,
	input  wire logic [tile_pkg::PRIO_W-1:0] prio_a,
	input  wire logic en_a,
	input  wire logic [tile_pkg::PLANES-1:0] dot_b,
	input  wire logic [tile_pkg::ATTR_W-1:0] color_b,
	input  wire logic [tile_pkg::PRIO_W-1:0] prio_b,
	input  wire logic en_b,
	input  wire logic [tile_pkg::PRIO_W-1:0] pri_in,
	input  wire logic [tile_pkg::ATTR_W-1:0] cl_in,
	input  wire logic [tile_pkg::PLANES-1:0] dt_in,
	output logic [tile_pkg::PRIO_W-1:0] pri_out,
	output logic [tile_pkg::ATTR_W-1:0] cl_out,
	output logic [tile_pkg::PLANES-1:0] dt_out,
	output logic pix_valid
);

	logic opaque_a;
	logic opaque_b;
	logic pick_b;
	logic layer_wins;
	logic [tile_pkg::PRIO_W-1:0] pick_prio;
	logic [tile_pkg::ATTR_W-1:0] pick_color;
	logic [tile_pkg::PLANES-1:0] pick_dot;

	assign opaque_a = en_a && (dot_a != tile_pkg::DOT_TRANSPARENT);
	assign opaque_b = en_b && (dot_b != tile_pkg::DOT_TRANSPARENT);

	// B beats A on strictly higher priority, or when A shows nothing
	assign pick_b = opaque_b && ((prio_b > prio_a) || !opaque_a);
	assign pick_prio = pick_b ? prio_b : prio_a;
	assign pick_color = pick_b ? color_b : color_a;
	assign pick_dot = pick_b ? dot_b : dot_a;

	// Ties with the chain go to the chain
	assign layer_wins = (pick_b || opaque_a) && (pick_prio > pri_in);

	////////////////////
	// Output register
	////////////////////
	always_ff @(posedge CLK_6M) begin
		pri_out <= layer_wins ? pick_prio : pri_in;
		cl_out <= layer_wins ? pick_color : cl_in;
		dt_out <= layer_wins ? pick_dot : dt_in;
	end

	// One cycle behind the pixel column
	always_ff @(posedge CLK_6M) begin
		if (reset) begin
			pix_valid <= 1'b0;
		end else begin
			pix_valid <= run;
		end
	end

endmodule

`default_nettype wire

// File: tilemap/tilemap_top.sv
`default_nettype none

// Dual tilemap pixel generator
module tilemap_top (
	input  wire logic CLK_6M,
	input  wire logic reset,
	// CPU register port
	input  wire logic cpu_req,
	output logic cpu_ack,
	input  wire ctrl_pkg::reg_sel_t cpu_addr,
	input  wire logic [ctrl_pkg::CPU_DW-1:0] cpu_wdata,
	// Tile memory side
	input  wire logic run,
	output tile_pkg::fetch_slot_t fetch_slot,
	input  wire logic [tile_pkg::GDI_W-1:0] gdi,
	input  wire logic [tile_pkg::ATTR_W-1:0] mdi,
	// Pixel chain in and out
	input  wire logic [tile_pkg::PRIO_W-1:0] pri_in,
	input  wire logic [tile_pkg::ATTR_W-1:0] cl_in,
	input  wire logic [tile_pkg::PLANES-1:0] dt_in,
	output logic [tile_pkg::PRIO_W-1:0] pri_out,
	output logic [tile_pkg::ATTR_W-1:0] cl_out,
	output logic [tile_pkg::PLANES-1:0] dt_out,
	output logic pix_valid
);

	logic [tile_pkg::PHASE_W-1:0] phase;
	logic tile_end;
	logic load;
	logic [tile_pkg::PRIO_W-1:0] prio_a;
	logic [tile_pkg::PRIO_W-1:0] prio_b;
	logic flip;
	logic en_a;
	logic en_b;
	logic [tile_pkg::PLANES-1:0] dot_a;
	logic [tile_pkg::PLANES-1:0] dot_b;
	logic [tile_pkg::ATTR_W-1:0] color_a;
	logic [tile_pkg::ATTR_W-1:0] color_b;

	// Only the phase drives the fetch schedule
	pixel_counter u_counter (
		.CLK_6M(CLK_6M), .reset(reset), .run(run),
		.phase(phase), .column(), .tile_end(tile_end)
	);

	fetch_sequencer u_fetch (
		.CLK_6M(CLK_6M), .reset(reset), .run(run), .phase(phase),
		.tile_end(tile_end), .slot(fetch_slot), .load(load)
	);

	layer_regs u_regs (
		.CLK_6M(CLK_6M), .reset(reset), .cpu_req(cpu_req), .cpu_ack(cpu_ack),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .prio_a(prio_a), .prio_b(prio_b),
		.flip(flip), .en_a(en_a), .en_b(en_b)
	);

	////////////////////
	// Layers
	////////////////////
	plane_shifter #(.LAYER_B(1'b0)) u_layer_a (
		.CLK_6M(CLK_6M), .reset(reset), .run(run), .slot(fetch_slot), .load(load),
		.gdi(gdi), .mdi(mdi), .flip(flip), .dot(dot_a), .color(color_a)
	);

	plane_shifter #(.LAYER_B(1'b1)) u_layer_b (
		.CLK_6M(CLK_6M), .reset(reset), .run(run), .slot(fetch_slot), .load(load),
		.gdi(gdi), .mdi(mdi), .flip(flip), .dot(dot_b), .color(color_b)
	);

	layer_mixer u_mixer (
		.CLK_6M(CLK_6M), .reset(reset), .run(run),
		.dot_a(dot_a), .color_a(color_a), .prio_a(prio_a), .en_a(en_a),
		.dot_b(dot_b), .color_b(color_b), .prio_b(prio_b), .en_b(en_b),
		.pri_in(pri_in), .cl_in(cl_in), .dt_in(dt_in),
		.pri_out(pri_out), .cl_out(cl_out), .dt_out(dt_out), .pix_valid(pix_valid)
	);

endmodule

`default_nettype wire

// File: bench/tilemap_sva.sv
`default_nettype none

// Protocol checks bound into the top level
module tilemap_sva (
	input  wire logic CLK_6M,
	input  wire logic reset,
	input  wire logic cpu_req,
	input  wire logic cpu_ack,
	input  wire logic run,
	input  wire logic [tile_pkg::PHASE_W-1:0] phase,
	input  wire tile_pkg::fetch_slot_t fetch_slot,
	input  wire logic [tile_pkg::PRIO_W-1:0] pri_out,
	input  wire logic [tile_pkg::ATTR_W-1:0] cl_out,
	input  wire logic [tile_pkg::PLANES-1:0] dt_out,
	input  wire logic pix_valid
);

	// Number of failed assertions
	int fail_count = 0;

	////////////////////
	// CPU handshake
	////////////////////
	// Ack only answers a pending request
	assert property (@(posedge CLK_6M) disable iff (reset) $rose(cpu_ack) |-> $past(cpu_req))
		else begin
			$error("cpu_ack rose without cpu_req");
			fail_count++;
		end

	// Ack holds until the host lets go
	assert property (@(posedge CLK_6M) disable iff (reset) $fell(cpu_ack) |-> !$past(cpu_req))
		else begin
			$error("cpu_ack fell while cpu_req was high");
			fail_count++;
		end

	////////////////////
	// Video side
	////////////////////
	// Fetches only while running, in the first half of a tile
	assert property (@(posedge CLK_6M) disable iff (reset)
		fetch_slot != tile_pkg::SLOT_NONE |-> run && (phase < tile_pkg::TILE_W / 2))
		else begin
			$error("fetch slot active outside phases 0-3 or while run is low");
			fail_count++;
		end

	assert property (@(posedge CLK_6M) disable iff (reset)
		pix_valid |-> !$isunknown({pri_out, cl_out, dt_out}))
		else begin
			$error("unknown pixel while pix_valid is high");
			fail_count++;
		end

endmodule

bind tilemap_top tilemap_sva u_sva (
	.CLK_6M(CLK_6M), .reset(reset), .cpu_req(cpu_req), .cpu_ack(cpu_ack),
	.run(run), .phase(phase), .fetch_slot(fetch_slot), .pri_out(pri_out),
	.cl_out(cl_out), .dt_out(dt_out), .pix_valid(pix_valid)
);

`default_nettype wire

// File: bench/tilemap_tb.sv
`default_nettype none

module tilemap_tb;

	logic CLK_6M;
	logic reset;
	logic cpu_req;
	logic cpu_ack;
	ctrl_pkg::reg_sel_t cpu_addr;
	logic [ctrl_pkg::CPU_DW-1:0] cpu_wdata;
	logic run;
	tile_pkg::fetch_slot_t fetch_slot;
	logic [tile_pkg::GDI_W-1:0] gdi;
	logic [tile_pkg::ATTR_W-1:0] mdi;
	logic [tile_pkg::PRIO_W-1:0] pri_in;
	logic [tile_pkg::ATTR_W-1:0] cl_in;
	logic [tile_pkg::PLANES-1:0] dt_in;
	logic [tile_pkg::PRIO_W-1:0] pri_out;
	logic [tile_pkg::ATTR_W-1:0] cl_out;
	logic [tile_pkg::PLANES-1:0] dt_out;
	logic pix_valid;

	// Register shadow, reset values of the port
	logic [tile_pkg::PRIO_W-1:0] m_prio_a = '0;
	logic [tile_pkg::PRIO_W-1:0] m_prio_b = '0;
	logic m_flip = 1'b0;
	logic m_en_a = 1'b1;
	logic m_en_b = 1'b1;

	// Tile memory, [layer][tile column]
	logic [tile_pkg::GDI_W-1:0] tile_lo [2][64];
	logic [tile_pkg::GDI_W-1:0] tile_hi [2][64];
	logic [tile_pkg::ATTR_W-1:0] tile_attr [2][64];

	// Expected pixels in column order, plus spot values from the file
	logic [tile_pkg::PRIO_W-1:0] exp_p [$];
	logic [tile_pkg::ATTR_W-1:0] exp_c [$];
	logic [tile_pkg::PLANES-1:0] exp_d [$];
	logic [13:0] spot [int];
	int out_count = 0;
	int error_count = 0;
	int limit_cycles = 0;
	logic [7:0] lfsr_state = 8'd95;
	string lines [$];

	tilemap_top uut (.*);

	initial begin
		CLK_6M = 1'b0;
		forever #5 CLK_6M = ~CLK_6M;
	end

	////////////////////
	// Reporting
	////////////////////
	task automatic fail_now(input string what);
		error_count++;
		$display("%s", what);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_pixel(input logic [tile_pkg::PRIO_W-1:0] got_p,
			input logic [tile_pkg::ATTR_W-1:0] got_c,
			input logic [tile_pkg::PLANES-1:0] got_d,
			input logic [tile_pkg::PRIO_W-1:0] want_p,
			input logic [tile_pkg::ATTR_W-1:0] want_c,
			input logic [tile_pkg::PLANES-1:0] want_d, input int col);
		if ({got_p, got_c, got_d} !== {want_p, want_c, want_d}) begin
			fail_now($sformatf("mismatch at %0t: column %0d got %0h/%0h/%0h want %0h/%0h/%0h",
				$time, col, got_p, got_c, got_d, want_p, want_c, want_d));
		end
	endtask

	task automatic check_ack(input logic got, input logic want, input string what);
		if (got !== want) begin
			fail_now($sformatf("mismatch at %0t: %s is %b, want %b", $time, what, got, want));
		end
	endtask

	task automatic check_slot(input tile_pkg::fetch_slot_t got, input tile_pkg::fetch_slot_t want);
		if (got !== want) begin
			fail_now($sformatf("mismatch at %0t: fetch_slot %s, want %s",
				$time, got.name(), want.name()));
		end
	endtask

	////////////////////
	// Models
	////////////////////
	// Fibonacci LFSR x^8+x^6+x^5+x^4+1, one step per bit
	function automatic logic [7:0] lfsr_take(input int nbits);
		logic [7:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			fb = ^(lfsr_state & 8'hB8);
			lfsr_state = {lfsr_state[6:0], fb};
			v = {v[6:0], fb};
		end
		return v;
	endfunction

	// Fetch slot due in each pixel phase of a tile
	function automatic tile_pkg::fetch_slot_t slot_for_phase(input int ph);
		case (ph)
			0: return tile_pkg::SLOT_A_LO;
			1: return tile_pkg::SLOT_A_HI;
			2: return tile_pkg::SLOT_B_LO;
			3: return tile_pkg::SLOT_B_HI;
			default: return tile_pkg::SLOT_NONE;
		endcase
	endfunction

	// Dot of a layer in screen column n, tile k-1 shows in tile column k
	function automatic logic [2:0] layer_dot(input int layer, input int n);
		logic [tile_pkg::GDI_W-1:0] word;
		logic [2:0] d;
		int k;
		int idx;
		if (n < tile_pkg::TILE_W) begin
			return tile_pkg::DOT_TRANSPARENT;
		end
		k = n / 8 - 1;
		idx = m_flip ? 7 - (n % 8) : n % 8;
		word = (idx < 4) ? tile_lo[layer][k] : tile_hi[layer][k];
		for (int p = 0; p < tile_pkg::PLANES; p++) begin
			// Nibble MSB is the leftmost pixel
			d[p] = word[p * 4 + 3 - (idx % 4)];
		end
		return d;
	endfunction

	task automatic push_expected(input int n);
		logic [2:0] da;
		logic [2:0] db;
		logic oa;
		logic ob;
		logic pb;
		logic [tile_pkg::PRIO_W-1:0] pp;
		da = layer_dot(0, n);
		db = layer_dot(1, n);
		oa = m_en_a && (da != 3'd7);
		ob = m_en_b && (db != 3'd7);
		pb = ob && ((m_prio_b > m_prio_a) || !oa);
		pp = pb ? m_prio_b : m_prio_a;
		if ((pb || oa) && (pp > pri_in)) begin
			exp_p.push_back(pp);
			exp_c.push_back(tile_attr[pb][n / 8 - 1]);
			exp_d.push_back(pb ? db : da);
		end else begin
			exp_p.push_back(pri_in);
			exp_c.push_back(cl_in);
			exp_d.push_back(dt_in);
		end
	endtask

	task automatic clear_tiles();
		for (int l = 0; l < 2; l++) begin
			for (int k = 0; k < 64; k++) begin
				tile_lo[l][k] = '1;
				tile_hi[l][k] = '1;
				tile_attr[l][k] = '0;
			end
		end
		spot.delete();
	endtask

	// Tile memory answers the slot shown this cycle
	task automatic drive_memory(input int n);
		int k;
		k = n / 8;
		gdi = '0;
		mdi = '0;
		case (fetch_slot)
			tile_pkg::SLOT_A_LO: gdi = tile_lo[0][k];
			tile_pkg::SLOT_A_HI: begin
				gdi = tile_hi[0][k];
				mdi = tile_attr[0][k];
			end
			tile_pkg::SLOT_B_LO: gdi = tile_lo[1][k];
			tile_pkg::SLOT_B_HI: begin
				gdi = tile_hi[1][k];
				mdi = tile_attr[1][k];
			end
			default: ;
		endcase
	endtask

	////////////////////
	// Host actions
	////////////////////
	task automatic write_reg(input int addr, input int data);
		@(negedge CLK_6M);
		check_ack(cpu_ack, 1'b0, "cpu_ack before request");
		cpu_addr = ctrl_pkg::reg_sel_t'(addr);
		cpu_wdata = data[7:0];
		cpu_req = 1'b1;
		@(negedge CLK_6M);
		check_ack(cpu_ack, 1'b1, "cpu_ack after request");
		cpu_req = 1'b0;
		case (addr)
			0: m_prio_a = data[2:0];
			1: m_prio_b = data[2:0];
			2: begin
				m_flip = data[ctrl_pkg::CTRL_FLIP];
				m_en_a = data[ctrl_pkg::CTRL_EN_A];
				m_en_b = data[ctrl_pkg::CTRL_EN_B];
			end
			default: ;
		endcase
		@(negedge CLK_6M);
		check_ack(cpu_ack, 1'b0, "cpu_ack after release");
	endtask

	task automatic run_scene(input int ncols, input int pri, input int cl, input int dt,
			input int rnd);
		out_count = 0;
		for (int n = 0; n < ncols; n++) begin
			@(negedge CLK_6M);
			run = 1'b1;
			if (rnd != 0) begin
				pri_in = lfsr_take(3);
				cl_in = lfsr_take(8);
				dt_in = lfsr_take(3);
			end else begin
				pri_in = pri;
				cl_in = cl;
				dt_in = dt;
			end
			push_expected(n);
			// Let the slot settle before the memory answers
			#1;
			check_slot(fetch_slot, slot_for_phase(n % tile_pkg::TILE_W));
			drive_memory(n);
		end
		@(negedge CLK_6M);
		run = 1'b0;
		gdi = '0;
		mdi = '0;
		while (exp_p.size() != 0) begin
			@(negedge CLK_6M);
		end
		repeat (2) @(negedge CLK_6M);
		check_ack(pix_valid, 1'b0, "pix_valid after run");
		if (out_count != ncols) begin
			fail_now($sformatf("scene gave %0d pixels, expected %0d", out_count, ncols));
		end
		clear_tiles();
	endtask

	// Output pixels counted by pix_valid
	always @(negedge CLK_6M) begin
		if (pix_valid === 1'b1) begin
			if (exp_p.size() == 0) begin
				fail_now("pix_valid high with no pixel outstanding");
			end
			check_pixel(pri_out, cl_out, dt_out, exp_p.pop_front(), exp_c.pop_front(),
				exp_d.pop_front(), out_count);
			if (spot.exists(out_count)) begin
				check_pixel(pri_out, cl_out, dt_out, spot[out_count][13:11],
					spot[out_count][10:3], spot[out_count][2:0], out_count);
			end
			out_count++;
		end
	end

	// Assertion failures from the bound checker
	always @(negedge CLK_6M) begin
		if (uut.u_sva.fail_count != 0) begin
			fail_now("an assertion in tilemap_sva failed");
		end
	end

	// Watchdog
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge CLK_6M);
		$display("watchdog expired after %0d cycles", limit_cycles);
		$display("STATUS: FAIL");
		$fatal(1, "run did not finish");
	end

	////////////////////
	// Main sequence
	////////////////////
	initial begin
		int fd;
		int a;
		int b;
		int c;
		int d;
		int e;
		int n_cols;
		int n_writes;
		string line;
		reset = 1'b1;
		cpu_req = 1'b0;
		cpu_addr = ctrl_pkg::REG_PRIO_A;
		cpu_wdata = '0;
		run = 1'b0;
		gdi = '0;
		mdi = '0;
		pri_in = '0;
		cl_in = '0;
		dt_in = '0;
		n_cols = 0;
		n_writes = 0;
		clear_tiles();
		fd = $fopen("bench/tilemap_stimulus.txt", "r");
		if (fd == 0) begin
			fail_now("cannot open bench/tilemap_stimulus.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
				lines.push_back(line);
				if (line.getc(0) == "w") begin
					n_writes++;
				end
				if (line.getc(0) == "s" && $sscanf(line, "s %d", a) == 1) begin
					n_cols += a;
				end
			end
		end
		$fclose(fd);
		limit_cycles = 10 * (n_cols + n_writes) + 200;
		repeat (3) @(posedge CLK_6M);
		@(negedge CLK_6M);
		reset = 1'b0;
		check_ack(cpu_ack, 1'b0, "cpu_ack after reset");
		check_ack(pix_valid, 1'b0, "pix_valid after reset");
		check_slot(fetch_slot, tile_pkg::SLOT_NONE);
		foreach (lines[i]) begin
			case (lines[i].getc(0))
				"w": begin
					void'($sscanf(lines[i], "w %h %h", a, b));
					write_reg(a, b);
				end
				"t": begin
					void'($sscanf(lines[i], "t %d %d %h %h %h", a, b, c, d, e));
					tile_lo[a][b] = c;
					tile_hi[a][b] = d;
					tile_attr[a][b] = e;
				end
				"e": begin
					void'($sscanf(lines[i], "e %d %h %h %h", a, b, c, d));
					spot[a] = {b[2:0], c[7:0], d[2:0]};
				end
				"s": begin
					void'($sscanf(lines[i], "s %d %h %h %h %d", a, b, c, d, e));
					run_scene(a, b, c, d, e);
				end
				default: fail_now($sformatf("unknown stimulus line: %s", lines[i]));
			endcase
		end
		if (error_count == 0 && uut.u_sva.fail_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/tilemap_stimulus.txt
# w addr data | t layer col lo hi attr | e col pri cl dt (spot value for next scene)
# s ncols pri cl dt random (chain constant unless random is 1), all values hex except counts
w 0 05
w 2 02
t 0 0 000 fff 3c
t 0 1 0f0 0f0 55
e 3 2 11 6
e 9 5 3c 0
e 13 2 11 6
e 20 5 55 2
s 24 2 11 6 0
w 1 06
w 2 06
t 0 0 000 fff 3c
t 1 0 fff 111 a0
t 0 1 000 000 3c
t 1 1 000 000 a0
e 9 5 3c 0
e 13 6 a0 0
e 15 1 22 4
e 18 6 a0 0
s 24 1 22 4 0
w 2 03
t 0 0 008 fff 3c
e 9 0 01 5
e 14 5 3c 0
e 15 5 3c 1
s 16 0 01 5 0
w 2 06
w 0 03
w 1 04
t 0 0 0f0 00f 12
t 0 1 777 888 34
t 0 2 f0f 0f0 56
t 1 0 00f f00 9a
t 1 1 3c3 c3c bc
t 1 2 fff 000 de
s 32 0 00 0 1

// File: filelist.f
common/tile_pkg.sv
common/ctrl_pkg.sv
logic/pixel_counter.sv
logic/fetch_sequencer.sv
logic/layer_regs.sv
tilemap/plane_shifter.sv
tilemap/layer_mixer.sv
tilemap/tilemap_top.sv
bench/tilemap_sva.sv
bench/tilemap_tb.sv

// File: Bender.yml
package:
  name: tilemap

sources:
  - common/tile_pkg.sv
  - common/ctrl_pkg.sv
  - logic/pixel_counter.sv
  - logic/fetch_sequencer.sv
  - logic/layer_regs.sv
  - tilemap/plane_shifter.sv
  - tilemap/layer_mixer.sv
  - tilemap/tilemap_top.sv
  - target: test
    files:
      - bench/tilemap_sva.sv
      - bench/tilemap_tb.sv
